//--- src/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    // instructions per fetch group, also the port count of the queue
    localparam int FETCH_WIDTH = 2;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_num_t;

    // register usage class, selected by inst[31:29]
    typedef enum logic [2:0] {
        REG_I,
        REG_RW,
        REG_RRW,
        REG_W,
        REG_RR,
        REG_BL,
        REG_RDCNTID,
        REG_INVTLB
    } reg_type_e;

    // two source registers and one destination
    typedef struct packed {
        reg_num_t [1:0] r_reg;
        reg_num_t       w_reg;
    } reg_info_t;

    // decoded record handed to the backend
    typedef struct packed {
        addr_t     pc;
        word_t     inst;
        reg_type_e reg_type;
        reg_info_t reg_info;
    } inst_t;

    // raw queue entry
    typedef struct packed {
        addr_t pc;
        word_t inst;
    } fetch_entry_t;

    // instruction bus, addr always 8-byte aligned
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } ibus_req_t;

    // low word is the even slot, high word the odd slot
    typedef struct packed {
        logic        valid;
        logic [63:0] data;
    } ibus_resp_t;

    // backend redirect, flush is a single-cycle pulse
    typedef struct packed {
        logic  flush;
        addr_t target;
    } redirect_t;

endpackage

`default_nettype wire

//--- src/pc_gen.sv
`timescale 1ns/10ps
`default_nettype none

module pc_gen import frontend_pkg::*; #(
    parameter addr_t RESET_PC = 32'h1c00_0000
) (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire redirect_t              redirect_i,
    input  wire logic                   group_ready_i,
    output logic                        group_valid_o,
    output addr_t                       group_pc_o,
    output logic [FETCH_WIDTH-1:0]      slot_mask_o
);

    // bit 2 of pc_q is only meaningful for the first group after a redirect
    addr_t pc_q;
    logic  first_q;

    assign group_pc_o = {pc_q[31:3], 3'b000};

    // odd start address skips the even slot of the first group
    assign slot_mask_o = {1'b1, ~(first_q & pc_q[2])};

    // nothing offered while the redirect is being taken
    assign group_valid_o = ~redirect_i.flush;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            // reset acts as a redirect to the boot address
            pc_q    <= RESET_PC;
            first_q <= 1'b1;
        end else if (redirect_i.flush) begin
            pc_q    <= redirect_i.target;
            first_q <= 1'b1;
        end else if (group_valid_o && group_ready_i) begin
            // sequential fetch, next aligned group
            pc_q    <= group_pc_o + 32'd8;
            first_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import frontend_pkg::*; (
    input  wire logic                           clk,
    input  wire logic                           rst_i,
    input  wire logic                           flush_i,
    input  wire logic                           group_valid_i,
    input  wire addr_t                          group_pc_i,
    input  wire logic [FETCH_WIDTH-1:0]         slot_mask_i,
    output logic                                group_ready_o,
    output ibus_req_t                           ibus_req_o,
    input  wire ibus_resp_t                     ibus_resp_i,
    input  wire logic                           write_ready_i,
    output logic [1:0]                          write_num_o,
    output fetch_entry_t [FETCH_WIDTH-1:0]      write_data_o
);

    typedef enum logic [1:0] {IDLE, WAIT_RESP, HOLD, DROP} state_e;

    state_e                 state_q;
    state_e                 state_d;
    logic                   req_q;
    addr_t                  pc_q;
    logic [FETCH_WIDTH-1:0] mask_q;
    logic [63:0]            data_q;
    logic [63:0]            data;
    logic                   accept;
    logic                   push;

    assign group_ready_o = (state_q == IDLE) && !flush_i;
    assign accept        = group_valid_i && group_ready_o;

    // one-cycle request pulse, then quiet until the response
    always_comb begin
        ibus_req_o = '{valid: req_q, addr: pc_q};
    end

    // held data replaces the bus data while waiting for queue space
    assign data = (state_q == HOLD) ? data_q : ibus_resp_i.data;
    assign push = ((state_q == WAIT_RESP && ibus_resp_i.valid) || state_q == HOLD)
                  && write_ready_i && !flush_i;

    always_comb begin
        write_num_o = 2'd0;
        if (push) begin
            write_num_o = {mask_q[0] & mask_q[1], mask_q[0] ^ mask_q[1]};
        end
        // a lone odd slot is packed down into entry 0
        write_data_o[0].pc   = {pc_q[31:3], ~mask_q[0], 2'b00};
        write_data_o[0].inst = mask_q[0] ? data[31:0] : data[63:32];
        write_data_o[1].pc   = {pc_q[31:3], 3'b100};
        write_data_o[1].inst = data[63:32];
    end

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = WAIT_RESP;
                end
            end
            WAIT_RESP: begin
                if (ibus_resp_i.valid) begin
                    state_d = (flush_i || push) ? IDLE : HOLD;
                end else if (flush_i) begin
                    // response still in flight, discard it when it lands
                    state_d = DROP;
                end
            end
            HOLD: begin
                if (flush_i || push) begin
                    state_d = IDLE;
                end
            end
            DROP: begin
                if (ibus_resp_i.valid) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
            req_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            req_q   <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q   <= group_pc_i;
            mask_q <= slot_mask_i;
        end
        if (state_q == WAIT_RESP && ibus_resp_i.valid) begin
            data_q <= ibus_resp_i.data;
        end
    end

endmodule

`default_nettype wire

//--- src/multi_channel_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module multi_channel_fifo import frontend_pkg::*; #(
    // power of two, at least 4
    parameter int DEPTH = 8
) (
    input  wire logic                           clk,
    input  wire logic                           rst_i,
    input  wire logic                           flush_i,
    input  wire logic [1:0]                     write_num_i,
    input  wire fetch_entry_t [FETCH_WIDTH-1:0] write_data_i,
    output logic                                write_ready_o,
    input  wire logic [1:0]                     read_num_i,
    output logic [FETCH_WIDTH-1:0]              read_valid_o,
    output fetch_entry_t [FETCH_WIDTH-1:0]      read_data_o
);

    localparam int PTR_W = $clog2(DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;

    fetch_entry_t mem_q [DEPTH];
    ptr_t         wr_ptr_q;
    ptr_t         rd_ptr_q;
    cnt_t         count_q;
    cnt_t         push_num;
    cnt_t         pop_num;

    // room for a full group
    assign write_ready_o = (cnt_t'(DEPTH) - count_q) >= cnt_t'(FETCH_WIDTH);

    always_comb begin
        push_num = write_ready_o ? cnt_t'(write_num_i) : '0;
        // never pop past what is stored
        if (cnt_t'(read_num_i) > count_q) begin
            pop_num = count_q;
        end else begin
            pop_num = cnt_t'(read_num_i);
        end
    end

    // storage, entries land at wr_ptr + k
    always_ff @(posedge clk) begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            if (!flush_i && cnt_t'(k) < push_num) begin
                mem_q[wr_ptr_q + ptr_t'(k)] <= write_data_i[k];
            end
        end
    end

    // flush empties the queue and wins over a write in the same cycle
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + ptr_t'(push_num);
            rd_ptr_q <= rd_ptr_q + ptr_t'(pop_num);
            count_q  <= count_q + push_num - pop_num;
        end
    end

    // oldest entries first, pointers wrap naturally
    always_comb begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            read_valid_o[k] = count_q > cnt_t'(k);
            read_data_o[k]  = mem_q[rd_ptr_q + ptr_t'(k)];
        end
    end

endmodule

`default_nettype wire

//--- src/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decoder import frontend_pkg::*; (
    input  wire word_t  inst_i,
    output reg_type_e   reg_type_o,
    output reg_info_t   reg_info_o
);

    reg_num_t field_a;
    reg_num_t field_b;
    reg_num_t field_d;

    // register fields common to all formats
    assign field_a = inst_i[14:10];
    assign field_b = inst_i[9:5];
    assign field_d = inst_i[4:0];

    assign reg_type_o = reg_type_e'(inst_i[31:29]);

    always_comb begin
        unique case (reg_type_o)
            REG_I: begin
                reg_info_o.r_reg[0] = '0;
                reg_info_o.r_reg[1] = '0;
                reg_info_o.w_reg    = '0;
            end
            REG_RW: begin
                reg_info_o.r_reg[0] = '0;
                reg_info_o.r_reg[1] = field_b;
                reg_info_o.w_reg    = field_d;
            end
            REG_RRW, REG_W: begin
                reg_info_o.r_reg[0] = field_a;
                reg_info_o.r_reg[1] = field_b;
                reg_info_o.w_reg    = field_d;
            end
            REG_RR: begin
                // stores and branches read rd as a source
                reg_info_o.r_reg[0] = field_d;
                reg_info_o.r_reg[1] = field_b;
                reg_info_o.w_reg    = '0;
            end
            REG_BL: begin
                // link register r1
                reg_info_o.r_reg[0] = '0;
                reg_info_o.r_reg[1] = '0;
                reg_info_o.w_reg    = 5'd1;
            end
            REG_RDCNTID: begin
                reg_info_o.r_reg[0] = '0;
                reg_info_o.r_reg[1] = '0;
                reg_info_o.w_reg    = field_b;
            end
            REG_INVTLB: begin
                reg_info_o.r_reg[0] = field_a;
                reg_info_o.r_reg[1] = field_b;
                reg_info_o.w_reg    = '0;
            end
            default: begin
                reg_info_o.r_reg[0] = '0;
                reg_info_o.r_reg[1] = '0;
                reg_info_o.w_reg    = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/frontend.sv
`timescale 1ns/10ps
`default_nettype none

module frontend import frontend_pkg::*; #(
    parameter addr_t RESET_PC   = 32'h1c00_0000,
    parameter int    FIFO_DEPTH = 8
) (
    input  wire logic                   clk,
    input  wire logic                   rst_i,
    input  wire redirect_t              redirect_i,
    output ibus_req_t                   ibus_req_o,
    input  wire ibus_resp_t             ibus_resp_i,
    output inst_t [FETCH_WIDTH-1:0]     inst_o,
    output logic [FETCH_WIDTH-1:0]      inst_valid_o,
    input  wire logic [1:0]             issue_num_i,
    input  wire logic                   backend_stall_i
);

    logic                           group_valid;
    logic                           group_ready;
    addr_t                          group_pc;
    logic [FETCH_WIDTH-1:0]         slot_mask;
    logic                           write_ready;
    logic [1:0]                     write_num;
    fetch_entry_t [FETCH_WIDTH-1:0] write_data;
    logic [1:0]                     read_num;
    fetch_entry_t [FETCH_WIDTH-1:0] read_data;
    reg_type_e [FETCH_WIDTH-1:0]    dec_type;
    reg_info_t [FETCH_WIDTH-1:0]    dec_info;

    pc_gen #(
        .RESET_PC(RESET_PC)
    ) pc_gen_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .redirect_i    (redirect_i),
        .group_ready_i (group_ready),
        .group_valid_o (group_valid),
        .group_pc_o    (group_pc),
        .slot_mask_o   (slot_mask)
    );

    fetch_unit fetch_unit_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (redirect_i.flush),
        .group_valid_i (group_valid),
        .group_pc_i    (group_pc),
        .slot_mask_i   (slot_mask),
        .group_ready_o (group_ready),
        .ibus_req_o    (ibus_req_o),
        .ibus_resp_i   (ibus_resp_i),
        .write_ready_i (write_ready),
        .write_num_o   (write_num),
        .write_data_o  (write_data)
    );

    // a stalled backend takes nothing
    assign read_num = backend_stall_i ? 2'd0 : issue_num_i;

    multi_channel_fifo #(
        .DEPTH(FIFO_DEPTH)
    ) fifo_i (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (redirect_i.flush),
        .write_num_i   (write_num),
        .write_data_i  (write_data),
        .write_ready_o (write_ready),
        .read_num_i    (read_num),
        .read_valid_o  (inst_valid_o),
        .read_data_o   (read_data)
    );

    // decode straight off the queue head
    for (genvar k = 0; k < FETCH_WIDTH; k++) begin : g_dec
        inst_decoder decoder_i (
            .inst_i     (read_data[k].inst),
            .reg_type_o (dec_type[k]),
            .reg_info_o (dec_info[k])
        );

        assign inst_o[k] = '{pc:       read_data[k].pc,
                             inst:     read_data[k].inst,
                             reg_type: dec_type[k],
                             reg_info: dec_info[k]};
    end

endmodule

`default_nettype wire

//--- tests/frontend_model.svh
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

// one LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// class bits follow the word index, the rest is hashed from the full address
function automatic word_t mem_word(input addr_t addr);
    logic [31:0] mix;
    mix = (addr ^ (addr >> 13)) * 32'h9e37_79b1;
    return {addr[4:2], mix[28:0]};
endfunction

function automatic reg_info_t pack_regs(input reg_num_t rd0, input reg_num_t rd1,
                                        input reg_num_t wr);
    reg_info_t info;
    info.r_reg[0] = rd0;
    info.r_reg[1] = rd1;
    info.w_reg    = wr;
    return info;
endfunction

// expected record for the word stored at pc
function automatic inst_t expected_inst(input addr_t pc);
    inst_t    rec;
    reg_num_t fa;
    reg_num_t fb;
    reg_num_t fd;
    rec.pc   = pc;
    rec.inst = mem_word(pc);
    fa = rec.inst[14:10];
    fb = rec.inst[9:5];
    fd = rec.inst[4:0];
    case (rec.inst[31:29])
        3'd0: begin
            rec.reg_type = REG_I;
            rec.reg_info = pack_regs(5'd0, 5'd0, 5'd0);
        end
        3'd1: begin
            rec.reg_type = REG_RW;
            rec.reg_info = pack_regs(5'd0, fb, fd);
        end
        3'd2: begin
            rec.reg_type = REG_RRW;
            rec.reg_info = pack_regs(fa, fb, fd);
        end
        3'd3: begin
            rec.reg_type = REG_W;
            rec.reg_info = pack_regs(fa, fb, fd);
        end
        3'd4: begin
            rec.reg_type = REG_RR;
            rec.reg_info = pack_regs(fd, fb, 5'd0);
        end
        3'd5: begin
            rec.reg_type = REG_BL;
            rec.reg_info = pack_regs(5'd0, 5'd0, 5'd1);
        end
        3'd6: begin
            rec.reg_type = REG_RDCNTID;
            rec.reg_info = pack_regs(5'd0, 5'd0, fb);
        end
        default: begin
            rec.reg_type = REG_INVTLB;
            rec.reg_info = pack_regs(fa, fb, 5'd0);
        end
    endcase
    return rec;
endfunction

`endif

//--- tests/tb_frontend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_frontend import frontend_pkg::*; ();

    localparam addr_t       RESET_PC   = 32'h1c00_0000;
    localparam int          FIFO_DEPTH = 8;
    localparam logic [31:0] SEED       = 32'h3679_6c9f;
    localparam int          MIN_INSTS  = 400;
    localparam int          MIN_FLUSH  = 8;
    localparam int          RUN_LIMIT  = 40000;

    `include "frontend_model.svh"

    logic                    clk;
    logic                    rst_i;
    redirect_t               redirect_i;
    ibus_req_t               ibus_req_o;
    ibus_resp_t              ibus_resp_i;
    inst_t [FETCH_WIDTH-1:0] inst_o;
    logic [FETCH_WIDTH-1:0]  inst_valid_o;
    logic [1:0]              issue_num_i;
    logic                    backend_stall_i;

    // bus model state
    logic [31:0] mem_rng;
    logic        mem_pending;
    addr_t       mem_addr;
    int          mem_delay;

    // expected stream
    addr_t exp_pc;
    int    consumed;

    frontend #(
        .RESET_PC   (RESET_PC),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) frontend_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .redirect_i      (redirect_i),
        .ibus_req_o      (ibus_req_o),
        .ibus_resp_i     (ibus_resp_i),
        .inst_o          (inst_o),
        .inst_valid_o    (inst_valid_o),
        .issue_num_i     (issue_num_i),
        .backend_stall_i (backend_stall_i)
    );

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // one response per request after 1 to 4 cycles
    initial begin
        mem_rng     = ~SEED;
        mem_pending = 1'b0;
        mem_addr    = '0;
        mem_delay   = 0;
        ibus_resp_i = '0;
        forever begin
            @(negedge clk);
            ibus_resp_i.valid <= 1'b0;
            if (mem_pending) begin
                if (mem_delay == 1) begin
                    ibus_resp_i.valid <= 1'b1;
                    ibus_resp_i.data  <= {mem_word(mem_addr + 32'd4), mem_word(mem_addr)};
                    mem_pending       <= 1'b0;
                end
                mem_delay <= mem_delay - 1;
            end
            if (ibus_req_o.valid) begin
                assert (!mem_pending)
                    else fail_run("bus request issued while a response was still pending");
                assert (ibus_req_o.addr[2:0] == 3'b000)
                    else fail_run($sformatf("Error: ibus_req_o.addr = %h, not 8-byte aligned",
                                            ibus_req_o.addr));
                mem_rng     = lcg_next(mem_rng);
                mem_pending <= 1'b1;
                mem_addr    <= ibus_req_o.addr;
                mem_delay   <= 1 + int'(mem_rng[17:16]);
            end
        end
    end

    // check every record the backend takes in mid-cycle
    initial begin
        inst_t want;
        exp_pc   = RESET_PC;
        consumed = 0;
        forever begin
            @(negedge clk);
            #5;
            if (!rst_i) begin
                assert (inst_valid_o != 2'b10)
                    else fail_run($sformatf("Error: inst_valid_o = %h, slot 1 without slot 0",
                                            inst_valid_o));
                if (redirect_i.flush) begin
                    exp_pc = redirect_i.target;
                end else if (!backend_stall_i) begin
                    for (int k = 0; k < int'(issue_num_i); k++) begin
                        want = expected_inst(exp_pc);
                        assert (inst_o[k].pc == want.pc)
                            else fail_run($sformatf("Error: inst_o[%0d].pc = %h, expected %h",
                                                    k, inst_o[k].pc, want.pc));
                        assert (inst_o[k].inst == want.inst)
                            else fail_run($sformatf("Error: inst_o[%0d].inst = %h, expected %h",
                                                    k, inst_o[k].inst, want.inst));
                        assert (inst_o[k].reg_type == want.reg_type)
                            else fail_run($sformatf("Error: inst_o[%0d].reg_type = %h, expected %h",
                                                    k, inst_o[k].reg_type, want.reg_type));
                        assert (inst_o[k].reg_info == want.reg_info)
                            else fail_run($sformatf("Error: inst_o[%0d].reg_info = %h, expected %h",
                                                    k, inst_o[k].reg_info, want.reg_info));
                        exp_pc   = exp_pc + 32'd4;
                        consumed = consumed + 1;
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] rng;
        int          cycles;
        int          stall_left;
        int          flush_gap;
        int          flushes;
        int          pick;
        logic        want_busy;
        logic        odd_target;

        rng             = SEED;
        rst_i           = 1'b1;
        redirect_i      = '0;
        issue_num_i     = 2'd0;
        backend_stall_i = 1'b0;
        stall_left      = 0;
        flush_gap       = 60;
        flushes         = 0;
        cycles          = 0;
        repeat (16) @(negedge clk);
        rst_i = 1'b0;
        assert (inst_valid_o == '0)
            else fail_run($sformatf("Error: inst_valid_o = %h after reset, expected 0",
                                    inst_valid_o));
        assert (ibus_req_o.valid == 1'b0)
            else fail_run($sformatf("Error: ibus_req_o.valid = %h after reset, expected 0",
                                    ibus_req_o.valid));

        while (consumed < MIN_INSTS || flushes < MIN_FLUSH) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) begin
                fail_run("timeout, the instruction stream stopped making progress");
            end
            redirect_i.flush = 1'b0;

            // long stall bursts between shorter free-running stretches
            if (stall_left == 0) begin
                rng             = lcg_next(rng);
                backend_stall_i = (rng[31:30] == 2'b00);
                stall_left      = (backend_stall_i ? 20 : 5) + int'(rng[20:16]);
            end
            stall_left--;

            // even flushes wait for a request in flight
            // every other pair of targets has bit 2 set
            if (flush_gap > 0) begin
                flush_gap--;
            end
            want_busy  = (flushes % 2 == 0);
            odd_target = (flushes % 4 >= 2);
            if (flush_gap == 0 && (mem_pending || !want_busy)) begin
                rng               = lcg_next(rng);
                redirect_i.flush  = 1'b1;
                redirect_i.target = RESET_PC + {17'h0, rng[27:16], odd_target, 2'b00};
                flush_gap         = 30 + int'(rng[7:2]);
                flushes++;
            end

            rng  = lcg_next(rng);
            pick = int'(rng[31:16]) % 3;
            if (pick > $countones(inst_valid_o)) begin
                pick = $countones(inst_valid_o);
            end
            if (redirect_i.flush) begin
                pick = 0;
            end
            issue_num_i = 2'(pick);
        end

        @(negedge clk);
        redirect_i.flush = 1'b0;
        issue_num_i      = 2'd0;
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+tests
src/frontend_pkg.sv
src/pc_gen.sv
src/fetch_unit.sv
src/multi_channel_fifo.sv
src/inst_decoder.sv
src/frontend.sv
tests/tb_frontend.sv

//--- Bender.yml
package:
  name: frontend

sources:
  - src/frontend_pkg.sv
  - src/pc_gen.sv
  - src/fetch_unit.sv
  - src/multi_channel_fifo.sv
  - src/inst_decoder.sv
  - src/frontend.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_frontend.sv
